// File: hdl/vread_defines.svh
`ifndef VREAD_DEFINES_SVH
`define VREAD_DEFINES_SVH

// databus word width
`define VR_AXI_DATA_W 32

// width of one output symbol
`define VR_DATA_W 16

// symbol address with the ping-pong half in the top bit
`define VR_ADDR_W 10

// word address into the local buffer
`define VR_BUF_ADDR_W 9

// period counters
`define VR_PERIOD_W 8

// burst length field
`define VR_LEN_W 8

// external memory address
`define VR_EXT_ADDR_W 32

// start delay of the output stream
`define VR_DELAY_W 4

`endif

// File: hdl/vread_pkg.sv
`include "vread_defines.svh"

package vread_pkg;

   // full run configuration, latched on run
   typedef struct packed {
      logic [`VR_EXT_ADDR_W-1:0] ext_addr;
      logic [`VR_LEN_W-1:0]      length;
      logic [`VR_ADDR_W-1:0]     rd_incr;
      logic [`VR_ADDR_W-1:0]     out_start;
      logic [`VR_PERIOD_W-1:0]   out_per;
      logic [`VR_ADDR_W-1:0]     out_incr;
      logic [`VR_DELAY_W-1:0]    out_delay;
      logic                      reverse;
      logic                      ping_pong;
      logic                      enable_read;
   } vread_cfg_t;

   // read request towards external memory
   typedef struct packed {
      logic                      valid;
      logic [`VR_EXT_ADDR_W-1:0] addr;
      logic [`VR_LEN_W-1:0]      len;
   } dbus_req_t;

   typedef struct packed {
      logic                      ready;
      logic [`VR_AXI_DATA_W-1:0] rdata;
      logic                      last;
   } dbus_rsp_t;

   // buffer ports
   typedef struct packed {
      logic                      en;
      logic [`VR_BUF_ADDR_W-1:0] addr;
      logic [`VR_AXI_DATA_W-1:0] data;
   } buf_wr_t;

   typedef struct packed {
      logic                      en;
      logic [`VR_BUF_ADDR_W-1:0] addr;
   } buf_rd_t;

   typedef enum logic [1:0] {
      IDLE,
      DELAY,
      ACTIVE
   } vread_state_e;

endpackage

// File: hdl/vread_addr_gen.sv
`timescale 1ns/1ps
`include "vread_defines.svh"

module vread_addr_gen #(
   parameter int ADDR_W = `VR_ADDR_W
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    start_i,
   input  logic [ADDR_W-1:0]       base_i,
   input  logic [ADDR_W-1:0]       incr_i,
   input  logic [`VR_PERIOD_W-1:0] period_i,
   input  logic [`VR_DELAY_W-1:0]  delay_i,
   input  logic                    step_i,
   output logic                    valid_o,
   output logic [ADDR_W-1:0]       addr_o,
   output logic                    done_o
);
   import vread_pkg::*;

   vread_state_e            state;
   logic [ADDR_W-1:0]       addr_q;
   logic [ADDR_W-1:0]       incr_q;
   logic [`VR_PERIOD_W-1:0] per_q;
   logic [`VR_PERIOD_W-1:0] cnt;
   logic [`VR_DELAY_W-1:0]  delay_cnt;
   logic                    last_step;

   // final address of the period is being consumed
   assign last_step = step_i && (cnt == per_q - 1'b1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= IDLE;
         cnt       <= '0;
         delay_cnt <= '0;
         done_o    <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (start_i) begin
            cnt       <= '0;
            delay_cnt <= delay_i;
            if (period_i == '0) begin
               // nothing to generate
               state  <= IDLE;
               done_o <= 1'b1;
            end else if (delay_i == '0) begin
               state <= ACTIVE;
            end else begin
               state <= DELAY;
            end
         end else begin
            case (state)
               DELAY: begin
                  delay_cnt <= delay_cnt - 1'b1;
                  if (delay_cnt == 1) state <= ACTIVE;
               end
               ACTIVE: begin
                  if (step_i) cnt <= cnt + 1'b1;
                  if (last_step) begin
                     state  <= IDLE;
                     done_o <= 1'b1;
                  end
               end
               default: state <= IDLE;
            endcase
         end
      end
   end

   // address and step size
   always_ff @(posedge clk) begin
      if (start_i) begin
         addr_q <= base_i;
         incr_q <= incr_i;
         per_q  <= period_i;
      end else if (state == ACTIVE && step_i) begin
         addr_q <= addr_q + incr_q;
      end
   end

   assign valid_o = (state == ACTIVE);
   assign addr_o  = addr_q;

endmodule

// File: hdl/vread_fetch.sv
`timescale 1ns/1ps
`include "vread_defines.svh"

module vread_fetch (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  vread_pkg::vread_cfg_t cfg_i,
   input  logic                  half_i,
   input  vread_pkg::dbus_rsp_t  dbus_rsp_i,
   output vread_pkg::dbus_req_t  dbus_req_o,
   output vread_pkg::buf_wr_t    buf_wr_o,
   output logic                  done_read_o
);
   import vread_pkg::*;

   // word index inside one half of the buffer
   localparam int WORD_W = `VR_BUF_ADDR_W - 1;

   logic                      done_read;
   logic                      accept;
   logic [`VR_EXT_ADDR_W-1:0] ext_addr_q;
   logic [`VR_PERIOD_W-1:0]   beats;
   logic                      gen_valid;
   logic [WORD_W-1:0]         gen_addr;
   logic                      wr_en_q;
   logic [`VR_BUF_ADDR_W-1:0] wr_addr_q;
   logic [`VR_AXI_DATA_W-1:0] wr_data_q;

   assign accept = dbus_req_o.valid && dbus_rsp_i.ready;
   assign beats  = cfg_i.length + 1'b1;

   // one word address per accepted beat
   vread_addr_gen #(
      .ADDR_W(WORD_W)
   ) u_wr_gen (
      .clk     (clk),
      .rst     (rst),
      .start_i (run_i && cfg_i.enable_read),
      .base_i  ('0),
      .incr_i  (cfg_i.rd_incr[WORD_W-1:0]),
      .period_i(beats),
      .delay_i ('0),
      .step_i  (accept),
      .valid_o (gen_valid),
      .addr_o  (gen_addr),
      .done_o  ()
   );

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done_read <= 1'b1;
         wr_en_q   <= 1'b0;
      end else begin
         wr_en_q <= accept && gen_valid;
         if (run_i) done_read <= !cfg_i.enable_read;
         else if (accept && dbus_rsp_i.last) done_read <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (run_i && cfg_i.enable_read) ext_addr_q <= cfg_i.ext_addr;
      // beat data goes to the write half
      wr_addr_q <= {half_i, gen_addr};
      wr_data_q <= dbus_rsp_i.rdata;
   end

   // request stays up until the last beat is taken
   always_comb begin
      dbus_req_o.valid = !done_read;
      dbus_req_o.addr  = ext_addr_q;
      dbus_req_o.len   = cfg_i.length;
   end

   always_comb begin
      buf_wr_o.en   = wr_en_q;
      buf_wr_o.addr = wr_addr_q;
      buf_wr_o.data = wr_data_q;
   end

   assign done_read_o = done_read;

endmodule

// File: hdl/vread_buffer.sv
`timescale 1ns/1ps
`include "vread_defines.svh"

module vread_buffer #(
   parameter int DEPTH_W = `VR_BUF_ADDR_W
) (
   input  logic                      clk,
   input  vread_pkg::buf_wr_t        wr_i,
   input  vread_pkg::buf_rd_t        rd_i,
   output logic [`VR_AXI_DATA_W-1:0] rdata_o
);

   // both ping-pong halves with the top address bit picking the half
   logic [`VR_AXI_DATA_W-1:0] mem [2**DEPTH_W];

   logic [DEPTH_W-1:0] wr_addr;
   logic [DEPTH_W-1:0] rd_addr;

   assign wr_addr = wr_i.addr[DEPTH_W-1:0];
   assign rd_addr = rd_i.addr[DEPTH_W-1:0];

   // write port, fed by the fetch stage
   always_ff @(posedge clk) begin
      if (wr_i.en) begin
         mem[wr_addr] <= wr_i.data;
      end
   end

   // read port with output register
   // holds its value between read strobes
   always_ff @(posedge clk) begin
      if (rd_i.en) begin
         rdata_o <= mem[rd_addr];
      end
   end

endmodule

// File: hdl/vread_output.sv
`timescale 1ns/1ps
`include "vread_defines.svh"

module vread_output (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      run_i,
   input  vread_pkg::vread_cfg_t     cfg_i,
   input  logic                      half_i,
   input  logic [`VR_AXI_DATA_W-1:0] rdata_i,
   output vread_pkg::buf_rd_t        buf_rd_o,
   output logic                      out_valid_o,
   output logic [`VR_DATA_W-1:0]     out_data_o,
   output logic                      done_out_o
);
   import vread_pkg::*;

   // symbols per word and the bits that select one
   localparam int SEL_W = $clog2(`VR_AXI_DATA_W / `VR_DATA_W);

   logic [`VR_ADDR_W-1:0] base;
   logic [`VR_ADDR_W-1:0] gen_addr;
   logic [`VR_ADDR_W-1:0] sym_addr;
   logic                  gen_valid;
   logic                  gen_done;
   logic                  gen_done_q;
   logic                  vld_q;
   logic [SEL_W-1:0]      sel_q;

   function automatic logic [`VR_ADDR_W-1:0] bit_rev(input logic [`VR_ADDR_W-1:0] a);
      logic [`VR_ADDR_W-1:0] r;
      for (int i = 0; i < `VR_ADDR_W; i++) r[i] = a[`VR_ADDR_W-1-i];
      return r;
   endfunction

   // ping-pong forces the half bit of the start address
   assign base = cfg_i.ping_pong ? {half_i, cfg_i.out_start[`VR_ADDR_W-2:0]} : cfg_i.out_start;

   vread_addr_gen #(
      .ADDR_W(`VR_ADDR_W)
   ) u_rd_gen (
      .clk(clk), .rst(rst), .start_i(run_i), .base_i(base), .incr_i(cfg_i.out_incr),
      .period_i(cfg_i.out_per), .delay_i(cfg_i.out_delay), .step_i(1'b1),
      .valid_o(gen_valid), .addr_o(gen_addr), .done_o(gen_done)
   );

   assign sym_addr = cfg_i.reverse ? bit_rev(gen_addr) : gen_addr;

   // symbol to word address
   always_comb begin
      buf_rd_o.en   = gen_valid;
      buf_rd_o.addr = {cfg_i.ping_pong & sym_addr[`VR_ADDR_W-1],
                       sym_addr[`VR_ADDR_W-2:SEL_W]};
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         vld_q       <= 1'b0;
         out_valid_o <= 1'b0;
         gen_done_q  <= 1'b0;
         done_out_o  <= 1'b1;
      end else begin
         vld_q       <= gen_valid;
         out_valid_o <= vld_q;
         gen_done_q  <= gen_done;
         // lines up with the last symbol leaving
         if (run_i) done_out_o <= 1'b0;
         else if (gen_done_q) done_out_o <= 1'b1;
      end
   end

   // halfword select rides along with the RAM read
   always_ff @(posedge clk) begin
      sel_q      <= sym_addr[SEL_W-1:0];
      out_data_o <= rdata_i[sel_q*`VR_DATA_W +: `VR_DATA_W];
   end

endmodule

// File: hdl/vread_top.sv
`timescale 1ns/1ps
`include "vread_defines.svh"

module vread_top (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  vread_pkg::vread_cfg_t cfg_i,
   input  vread_pkg::dbus_rsp_t  dbus_rsp_i,
   output vread_pkg::dbus_req_t  dbus_req_o,
   output logic                  out_valid_o,
   output logic [`VR_DATA_W-1:0] out_data_o,
   output logic                  done_o
);
   import vread_pkg::*;

   vread_cfg_t                cfg_q;
   vread_cfg_t                cfg_cur;
   logic                      pp_state;
   logic                      pp_next;
   logic                      half;
   buf_wr_t                   buf_wr;
   buf_rd_t                   buf_rd;
   logic [`VR_AXI_DATA_W-1:0] buf_rdata;
   logic                      done_read;
   logic                      done_out;

   always_ff @(posedge clk) begin
      if (run_i) cfg_q <= cfg_i;
   end

   // stages see the live config in the run cycle
   assign cfg_cur = run_i ? cfg_i : cfg_q;

   // toggle on each run with ping-pong, else back to half 0
   assign pp_next = cfg_i.ping_pong ? !pp_state : 1'b0;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) pp_state <= 1'b0;
      else if (run_i) pp_state <= pp_next;
   end

   assign half = run_i ? pp_next : pp_state;

   // fetch fills the half the output is not reading
   vread_fetch u_fetch (
      .clk(clk), .rst(rst), .run_i(run_i), .cfg_i(cfg_cur), .half_i(!half),
      .dbus_rsp_i(dbus_rsp_i), .dbus_req_o(dbus_req_o), .buf_wr_o(buf_wr),
      .done_read_o(done_read)
   );

   vread_buffer #(
      .DEPTH_W(`VR_BUF_ADDR_W)
   ) u_buffer (
      .clk(clk), .wr_i(buf_wr), .rd_i(buf_rd), .rdata_o(buf_rdata)
   );

   vread_output u_output (
      .clk(clk), .rst(rst), .run_i(run_i), .cfg_i(cfg_cur), .half_i(half),
      .rdata_i(buf_rdata), .buf_rd_o(buf_rd), .out_valid_o(out_valid_o),
      .out_data_o(out_data_o), .done_out_o(done_out)
   );

   assign done_o = done_read & done_out;

endmodule

// File: tests/vread_properties.sv
`timescale 1ns/1ps

module vread_properties (
   input logic                 clk,
   input logic                 rst,
   input vread_pkg::dbus_req_t dbus_req_i,
   input vread_pkg::dbus_rsp_t dbus_rsp_i,
   input logic                 out_valid_i,
   input logic                 done_i
);

   // request stays up until the beat with last is taken
   property valid_held_p;
      @(posedge clk) disable iff (rst)
         dbus_req_i.valid && !(dbus_rsp_i.ready && dbus_rsp_i.last) |=> dbus_req_i.valid;
   endproperty

   property done_after_reset_p;
      @(posedge clk) $fell(rst) |-> done_i;
   endproperty

   // a stream only starts while a run is pending
   property no_output_when_done_p;
      @(posedge clk) disable iff (rst)
         $rose(out_valid_i) |-> !done_i;
   endproperty

   assert property (valid_held_p) else $error("databus valid dropped before the last beat");
   assert property (done_after_reset_p) else $error("done low after reset release");
   assert property (no_output_when_done_p) else $error("output started while done was high");

endmodule

bind vread_top vread_properties u_props (
   .clk(clk), .rst(rst), .dbus_req_i(dbus_req_o), .dbus_rsp_i(dbus_rsp_i),
   .out_valid_i(out_valid_o), .done_i(done_o)
);

// File: tests/vread_tb.sv
`timescale 1ns/1ps
`include "vread_defines.svh"

module vread_tb;
   import vread_pkg::*;

   localparam int TIMEOUT = 2000;

   logic                      clk;
   logic                      rst;
   logic                      run;
   vread_cfg_t                cfg;
   dbus_rsp_t                 dbus_rsp;
   dbus_req_t                 dbus_req;
   logic                      out_valid;
   logic [`VR_DATA_W-1:0]     out_data;
   logic                      done;

   logic [31:0]               gold [0:511];
   int                        gi;
   logic [31:0]               lfsr;
   logic [`VR_AXI_DATA_W-1:0] beat_mem [0:255];
   int                        beat_idx;
   int                        beats_left;
   logic                      acc_pending;
   logic [`VR_EXT_ADDR_W-1:0] cur_ext_addr;
   logic [`VR_LEN_W-1:0]      cur_len;
   logic [`VR_DATA_W-1:0]     exp_q [$];
   int                        run_cycle;
   int                        next_sym_cycle;

   vread_top u_vread_top (
      .clk(clk), .rst(rst), .run_i(run), .cfg_i(cfg), .dbus_rsp_i(dbus_rsp),
      .dbus_req_o(dbus_req), .out_valid_o(out_valid), .out_data_o(out_data),
      .done_o(done)
   );

   always #10 clk = ~clk;

   // galois form with taps of x^32+x^22+x^2+x+1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic abort_sim(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp) begin
         abort_sim($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
      end
   endtask

   task automatic take_word(output logic [31:0] w);
      w = gold[gi];
      gi++;
      if ($isunknown(w)) abort_sim("golden file ended in the middle of a record");
   endtask

   // one cycle of the memory model plus the output monitor
   task automatic tick();
      @(negedge clk);
      run_cycle++;
      if (acc_pending) begin
         beat_idx++;
         beats_left--;
      end
      if (done && (beats_left != 0 || exp_q.size() != 0)) begin
         abort_sim("done went high before the fetch and the stream had finished");
      end
      if (out_valid) begin
         if (exp_q.size() == 0) begin
            abort_sim("output symbol arrived when none was expected");
         end else begin
            check_eq(run_cycle, next_sym_cycle, "output symbol cycle");
            check_eq(out_data, exp_q.pop_front(), "output symbol");
            next_sym_cycle++;
         end
      end
      lfsr = lfsr_step(lfsr);
      dbus_rsp.ready = lfsr[0];
      dbus_rsp.rdata = (beats_left != 0) ? beat_mem[beat_idx] : '0;
      dbus_rsp.last  = (beats_left == 1);
      // valid only moves on posedge, so this is what the next edge sees
      acc_pending = 1'b0;
      if (dbus_req.valid) begin
         if (beats_left == 0) begin
            abort_sim("databus request with no beat left to transfer");
         end else if (dbus_rsp.ready) begin
            check_eq(dbus_req.addr, cur_ext_addr, "databus address");
            check_eq(dbus_req.len, cur_len, "databus length");
            acc_pending = 1'b1;
         end
      end
   endtask

   task automatic run_test(input int num);
      logic [31:0] f [0:7];
      logic [31:0] w;
      vread_cfg_t  c;
      int          nsym;
      int          n;
      for (int i = 0; i < 8; i++) take_word(f[i]);
      c.ext_addr    = f[0];
      c.length      = f[1][`VR_LEN_W-1:0];
      c.rd_incr     = f[2][`VR_ADDR_W-1:0];
      c.out_start   = f[3][`VR_ADDR_W-1:0];
      c.out_per     = f[4][`VR_PERIOD_W-1:0];
      c.out_incr    = f[5][`VR_ADDR_W-1:0];
      c.out_delay   = f[6][`VR_DELAY_W-1:0];
      c.reverse     = f[7][2];
      c.ping_pong   = f[7][1];
      c.enable_read = f[7][0];
      for (int k = 0; k <= int'(c.length); k++) take_word(beat_mem[k]);
      take_word(w);
      nsym = w;
      for (int k = 0; k < nsym; k++) begin
         take_word(w);
         exp_q.push_back(w[`VR_DATA_W-1:0]);
      end
      cur_ext_addr = c.ext_addr;
      cur_len      = c.length;
      beat_idx     = 0;
      beats_left   = c.enable_read ? int'(c.length) + 1 : 0;
      // first address right after the delay and its symbol two cycles later
      run_cycle      = 0;
      next_sym_cycle = int'(c.out_delay) + 3;
      // single-cycle run strobe
      cfg = c;
      run = 1'b1;
      tick();
      run = 1'b0;
      check_eq(dbus_req.valid, c.enable_read, "databus valid after run");
      n = 0;
      while (!(done === 1'b1 && beats_left == 0 && exp_q.size() == 0)) begin
         if (n == TIMEOUT) begin
            abort_sim($sformatf("timeout in test %0d: done, beats or symbols never came", num));
         end else begin
            tick();
            n++;
         end
      end
      // a few quiet cycles to catch stray symbols
      repeat (4) tick();
      $display("test %0d finished after %0d cycles", num, n);
   endtask

   initial begin
      int          ntests;
      logic [31:0] w;
      clk            = 1'b0;
      rst            = 1'b1;
      run            = 1'b0;
      cfg            = '0;
      dbus_rsp       = '0;
      lfsr           = 32'ha70f1665;
      acc_pending    = 1'b0;
      beat_idx       = 0;
      beats_left     = 0;
      cur_ext_addr   = '0;
      cur_len        = '0;
      run_cycle      = 0;
      next_sym_cycle = 0;
      gi             = 0;
      $readmemh("tests/vread_golden.txt", gold);
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      tick();
      check_eq(done, 1'b1, "done after reset");
      take_word(w);
      ntests = w;
      for (int t = 1; t <= ntests; t++) run_test(t);
      $display("TEST OK");
      $finish;
   end

endmodule

// File: tests/vread_golden.txt
// per test: ext_addr length rd_incr out_start out_per out_incr out_delay flags{rev,pp,rd}
// then length+1 beat words, the expected symbol count and the expected symbols
05
// fetch into half 0, no output symbols
10000040 05 001 000 00 000 0 3
10021001 10041003 10061005 10081007 100a1009 100c100b
00
// ping-pong stream of half 0 while half 1 fills
20000000 05 001 000 0c 001 0 3
20022001 20042003 20062005 20082007 200a2009 200c200b
0c
1001 1002 1003 1004 1005 1006 1007 1008 1009 100a 100b 100c
// incr 3 and delay 5 over half 1, fetch into even words of half 0
30000100 03 002 001 04 003 5 3
30023001 30043003 30063005 30083007
04
2002 2005 2008 200b
// bit-reversed addresses over half 0, fetch with rd_incr 3 into half 1
40000000 01 003 000 07 040 2 7
40024001 40044003
07
3001 3005 3003 3007 1003 100b 1007
// read disabled, replays half 1, the single beat word is unused
50000000 00 001 000 06 001 1 2
00000000
06
4001 4002 2003 2004 2005 2006

// File: tb.f
+incdir+hdl
hdl/vread_pkg.sv
hdl/vread_addr_gen.sv
hdl/vread_fetch.sv
hdl/vread_buffer.sv
hdl/vread_output.sv
hdl/vread_top.sv
tests/vread_properties.sv
tests/vread_tb.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, then decide pass or fail from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vread_tb -f tb.f \
   -Mdir obj_dir -o vread_sim \
   && { ./obj_dir/vread_sim > sim.log 2>&1 || true; } \
   && cat sim.log \
   && grep -q "TEST OK" sim.log \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
